// File: all.f
+incdir+logic
logic/arch_pkg.sv
logic/phys_pkg.sv
logic/map_table.sv
logic/free_list.sv
logic/rename_ctrl.sv
logic/rename_top.sv
verif/rename_chk.sv
verif/rename_tb.sv

// File: run.sh
#!/bin/sh
# Build with Verilator, run, then scan the log for the fail message
verilator --binary --timing --assert -Wno-fatal -f all.f --top-module rename_tb -o rename_sim \
    && ./obj_dir/rename_sim > sim.log 2>&1 \
    && ! grep -q "ERRORS FOUND" sim.log \
    && echo "Simulation passed" \
    || { echo "Simulation failed, see sim.log"; exit 1; }

// File: verif/rename_tb.sv
//--------------------------------------------------------------------------
// Register rename testbench
//--------------------------------------------------------------------------

`timescale 1ns/1ps

`include "rename_config.svh"

module rename_tb;

    typedef struct packed {
        phys_pkg::phys_tag_t src1;
        phys_pkg::phys_tag_t src2;
        phys_pkg::phys_tag_t dest;
        phys_pkg::phys_tag_t old;
    } item_t;

    logic                clk_i;
    logic                rst_i;
    logic                dp_valid_i;
    arch_pkg::arch_reg_t dp_src1_i;
    arch_pkg::arch_reg_t dp_src2_i;
    arch_pkg::arch_reg_t dp_dest_i;
    logic                dp_wr_i;
    logic                dp_ready_o;
    logic                rn_valid_o;
    phys_pkg::phys_tag_t rn_src1_tag_o;
    phys_pkg::phys_tag_t rn_src2_tag_o;
    phys_pkg::phys_tag_t rn_dest_tag_o;
    phys_pkg::phys_tag_t rn_old_tag_o;
    logic                rn_ready_i;
    logic                rt_valid_i;
    phys_pkg::phys_tag_t rt_tag_i;

    // Reference model state
    phys_pkg::phys_tag_t map_m [`ARCH_REG_NUM];
    phys_pkg::phys_tag_t free_q[$];
    item_t               exp_q[$];
    phys_pkg::phys_tag_t pending_q[$];

    int seed = 31;
    int cnt;

    rename_top i_dut (.*);

    initial begin
        clk_i = 1'b0;
        forever #20 clk_i = ~clk_i;
    end

    task automatic stop_with_failure();
        $display("ERRORS FOUND");
        $fatal(1);
    endtask

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("[FAIL] %s: got 0x%0h, expected 0x%0h", name, got, exp);
            stop_with_failure();
        end
    endtask

    task automatic report_timeout(input string what);
        $display("Timeout while waiting for %s", what);
        stop_with_failure();
    endtask

    //----------------------------------------------------------------------
    // One clock cycle of stimulus, checking and model update
    //----------------------------------------------------------------------

    task automatic step(input bit allow_retire, input bit allow_dispatch);
        logic [31:0] rnd;
        int          idx;
        logic        alloc;
        logic        exp_ready;
        item_t       item;
        @(negedge clk_i);
        rnd = $random(seed);
        // Sink stalls about a quarter of the time
        rn_ready_i = (rnd[1:0] != 2'b00);
        dp_valid_i = allow_dispatch && (rnd[4:2] != 3'b000);
        dp_wr_i    = (rnd[6:5] != 2'b00);
        dp_src1_i  = rnd[11:7];
        dp_src2_i  = rnd[16:12];
        dp_dest_i  = rnd[21:17];
        rt_valid_i = 1'b0;
        rt_tag_i   = '0;
        if (allow_retire && rnd[22] && pending_q.size() != 0) begin
            // Retire any old tag already seen
            rnd = $random(seed);
            idx = int'(rnd[15:0]) % pending_q.size();
            rt_valid_i = 1'b1;
            rt_tag_i   = pending_q[idx];
            pending_q.delete(idx);
        end
        #1;
        check("rn_valid_o", 32'(rn_valid_o), 32'(exp_q.size() != 0));
        alloc     = dp_wr_i && (dp_dest_i != '0);
        exp_ready = (exp_q.size() == 0 || rn_ready_i) && (!alloc || free_q.size() != 0);
        check("dp_ready_o", 32'(dp_ready_o), 32'(exp_ready));
        // Item leaving on the coming edge
        if (rn_valid_o && rn_ready_i) begin
            item = exp_q.pop_front();
            check("rn_src1_tag_o", 32'(rn_src1_tag_o), 32'(item.src1));
            check("rn_src2_tag_o", 32'(rn_src2_tag_o), 32'(item.src2));
            check("rn_dest_tag_o", 32'(rn_dest_tag_o), 32'(item.dest));
            check("rn_old_tag_o", 32'(rn_old_tag_o), 32'(item.old));
            if (item.old != '0) begin
                pending_q.push_back(item.old);
            end
        end
        // Sources read before this instruction's own update
        if (dp_valid_i && exp_ready) begin
            item.src1 = map_m[dp_src1_i];
            item.src2 = map_m[dp_src2_i];
            item.dest = '0;
            item.old  = '0;
            if (alloc) begin
                item.dest = free_q.pop_front();
                item.old  = map_m[dp_dest_i];
                map_m[dp_dest_i] = item.dest;
            end
            exp_q.push_back(item);
        end
        // Retired tag lands behind any pop
        if (rt_valid_i) begin
            free_q.push_back(rt_tag_i);
        end
    endtask

    //----------------------------------------------------------------------
    // Test sequence
    //----------------------------------------------------------------------

    initial begin
        rst_i      = 1'b1;
        dp_valid_i = 1'b0;
        dp_src1_i  = '0;
        dp_src2_i  = '0;
        dp_dest_i  = '0;
        dp_wr_i    = 1'b0;
        rn_ready_i = 1'b0;
        rt_valid_i = 1'b0;
        rt_tag_i   = '0;
        for (int i = 0; i < `ARCH_REG_NUM; i++) begin
            map_m[i] = phys_pkg::phys_tag_t'(i);
        end
        for (int i = 0; i < `FL_DEPTH; i++) begin
            free_q.push_back(phys_pkg::phys_tag_t'(`ARCH_REG_NUM + i));
        end
        // Four rising edges under reset, released on the next falling edge
        repeat (4) @(posedge clk_i);
        @(negedge clk_i);
        rst_i = 1'b0;

        // Use up the free list with nothing retired
        cnt = 0;
        while (free_q.size() != 0) begin
            step(1'b0, 1'b1);
            cnt++;
            if (cnt > 400) report_timeout("free list to run empty");
        end
        // Allocating instructions must stall while others pass
        repeat (40) step(1'b0, 1'b1);

        // Mixed traffic with retires
        repeat (3000) step(1'b1, 1'b1);

        // Drain the output register
        cnt = 0;
        while (exp_q.size() != 0) begin
            step(1'b1, 1'b0);
            cnt++;
            if (cnt > 50) report_timeout("rename output to drain");
        end

        $display("NO ERRORS");
        $finish;
    end

endmodule

// File: verif/rename_chk.sv
//--------------------------------------------------------------------------
// Rename output checks
//--------------------------------------------------------------------------

`timescale 1ns/1ps

module rename_chk (
    input logic                clk_i,
    input logic                rst_i,
    input logic                rn_valid_o,
    input logic                rn_ready_i,
    input phys_pkg::phys_tag_t rn_src1_tag_o,
    input phys_pkg::phys_tag_t rn_src2_tag_o,
    input phys_pkg::phys_tag_t rn_dest_tag_o,
    input phys_pkg::phys_tag_t rn_old_tag_o
);

    // Output slot empty right after reset
    a_reset_empty: assert property (@(posedge clk_i) rst_i |=> !rn_valid_o)
        else $error("Rename output valid in the cycle after reset");

    // Stalled item keeps every field
    a_hold_stable: assert property (@(posedge clk_i) disable iff (rst_i)
        (rn_valid_o && !rn_ready_i) |=> (rn_valid_o
            && $stable(rn_src1_tag_o) && $stable(rn_src2_tag_o)
            && $stable(rn_dest_tag_o) && $stable(rn_old_tag_o)))
        else $error("Rename output changed under back-pressure");

    // An old tag only comes with a real allocation
    a_old_needs_dest: assert property (@(posedge clk_i) disable iff (rst_i)
        (rn_valid_o && rn_old_tag_o != '0) |-> (rn_dest_tag_o != '0))
        else $error("Old tag set without a destination tag");

endmodule

bind rename_top rename_chk i_chk (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .rn_valid_o    (rn_valid_o),
    .rn_ready_i    (rn_ready_i),
    .rn_src1_tag_o (rn_src1_tag_o),
    .rn_src2_tag_o (rn_src2_tag_o),
    .rn_dest_tag_o (rn_dest_tag_o),
    .rn_old_tag_o  (rn_old_tag_o)
);

// File: logic/rename_top.sv
//--------------------------------------------------------------------------
// Register rename top level
//--------------------------------------------------------------------------

`timescale 1ns/1ps

`include "rename_config.svh"

module rename_top (
    input  logic                clk_i,
    input  logic                rst_i,
    // Dispatch in
    input  logic                dp_valid_i,
    input  arch_pkg::arch_reg_t dp_src1_i,
    input  arch_pkg::arch_reg_t dp_src2_i,
    input  arch_pkg::arch_reg_t dp_dest_i,
    input  logic                dp_wr_i,
    output logic                dp_ready_o,
    // Rename out
    output logic                rn_valid_o,
    output phys_pkg::phys_tag_t rn_src1_tag_o,
    output phys_pkg::phys_tag_t rn_src2_tag_o,
    output phys_pkg::phys_tag_t rn_dest_tag_o,
    output phys_pkg::phys_tag_t rn_old_tag_o,
    input  logic                rn_ready_i,
    // Retire in
    input  logic                rt_valid_i,
    input  phys_pkg::phys_tag_t rt_tag_i
);

    phys_pkg::phys_tag_t src1_tag;
    phys_pkg::phys_tag_t src2_tag;
    phys_pkg::phys_tag_t old_tag;
    phys_pkg::phys_tag_t free_tag;
    logic                fl_empty;
    logic                mt_wr;
    logic                fl_pop;

    //----------------------------------------------------------------------
    // Map table, indexed straight from dispatch
    //----------------------------------------------------------------------

    map_table i_map_table (
        .clk_i     (clk_i),
        .rst_i     (rst_i),
        .rd1_idx_i (dp_src1_i),
        .rd2_idx_i (dp_src2_i),
        .rd3_idx_i (dp_dest_i),
        .rd1_tag_o (src1_tag),
        .rd2_tag_o (src2_tag),
        .rd3_tag_o (old_tag),
        .wr_en_i   (mt_wr),
        .wr_idx_i  (dp_dest_i),
        // Head tag becomes the new mapping
        .wr_tag_i  (free_tag)
    );

    // Retire port pushes straight in
    free_list i_free_list (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .pop_i      (fl_pop),
        .push_i     (rt_valid_i),
        .push_tag_i (rt_tag_i),
        .head_tag_o (free_tag),
        .empty_o    (fl_empty)
    );

    //----------------------------------------------------------------------
    // Controller
    //----------------------------------------------------------------------

    rename_ctrl i_rename_ctrl (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .dp_valid_i    (dp_valid_i),
        .dp_wr_i       (dp_wr_i),
        .dp_dest_i     (dp_dest_i),
        .dp_ready_o    (dp_ready_o),
        .src1_tag_i    (src1_tag),
        .src2_tag_i    (src2_tag),
        .old_tag_i     (old_tag),
        .free_tag_i    (free_tag),
        .fl_empty_i    (fl_empty),
        .mt_wr_o       (mt_wr),
        .fl_pop_o      (fl_pop),
        .rn_valid_o    (rn_valid_o),
        .rn_src1_tag_o (rn_src1_tag_o),
        .rn_src2_tag_o (rn_src2_tag_o),
        .rn_dest_tag_o (rn_dest_tag_o),
        .rn_old_tag_o  (rn_old_tag_o),
        .rn_ready_i    (rn_ready_i)
    );

endmodule

// File: logic/rename_ctrl.sv
//--------------------------------------------------------------------------
// Rename controller
//--------------------------------------------------------------------------

`timescale 1ns/1ps

`include "rename_config.svh"

module rename_ctrl (
    input  logic                clk_i,
    input  logic                rst_i,
    // Dispatch handshake
    input  logic                dp_valid_i,
    input  logic                dp_wr_i,
    input  arch_pkg::arch_reg_t dp_dest_i,
    output logic                dp_ready_o,
    // Lookup results from map table and free list
    input  phys_pkg::phys_tag_t src1_tag_i,
    input  phys_pkg::phys_tag_t src2_tag_i,
    input  phys_pkg::phys_tag_t old_tag_i,
    input  phys_pkg::phys_tag_t free_tag_i,
    input  logic                fl_empty_i,
    // Update strobes
    output logic                mt_wr_o,
    output logic                fl_pop_o,
    // Renamed instruction
    output logic                rn_valid_o,
    output phys_pkg::phys_tag_t rn_src1_tag_o,
    output phys_pkg::phys_tag_t rn_src2_tag_o,
    output phys_pkg::phys_tag_t rn_dest_tag_o,
    output phys_pkg::phys_tag_t rn_old_tag_o,
    input  logic                rn_ready_i
);

    logic alloc_need;
    logic out_free;
    logic accept;

    //----------------------------------------------------------------------
    // Handshake and allocation
    //----------------------------------------------------------------------

    // Writes to reg 0 are dropped, no tag taken
    assign alloc_need = dp_wr_i && (dp_dest_i != '0);

    // Output slot empty or draining this cycle
    assign out_free = !rn_valid_o || rn_ready_i;

    // Stall only allocating instructions on an empty list
    assign dp_ready_o = out_free && (!alloc_need || !fl_empty_i);
    assign accept     = dp_valid_i && dp_ready_o;

    // Map update and tag pop happen on the accepting edge
    assign mt_wr_o  = accept && alloc_need;
    assign fl_pop_o = accept && alloc_need;

    //----------------------------------------------------------------------
    // Output register
    //----------------------------------------------------------------------

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            rn_valid_o <= 1'b0;
        end else if (accept) begin
            rn_valid_o <= 1'b1;
        end else if (rn_ready_i) begin
            // Drained with nothing behind it
            rn_valid_o <= 1'b0;
        end
    end

    // Payload moves only on acceptance, held otherwise
    always_ff @(posedge clk_i) begin
        if (accept) begin
            rn_src1_tag_o <= src1_tag_i;
            rn_src2_tag_o <= src2_tag_i;
            // Non-allocating instructions carry zero tags
            rn_dest_tag_o <= alloc_need ? free_tag_i : '0;
            rn_old_tag_o  <= alloc_need ? old_tag_i : '0;
        end
    end

endmodule

// File: logic/free_list.sv
//--------------------------------------------------------------------------
// Physical tag free list
//--------------------------------------------------------------------------

`timescale 1ns/1ps

`include "rename_config.svh"

module free_list (
    input  logic                clk_i,
    input  logic                rst_i,
    // Allocation side
    input  logic                pop_i,
    // Retire side
    input  logic                push_i,
    input  phys_pkg::phys_tag_t push_tag_i,
    // Next tag to hand out
    output phys_pkg::phys_tag_t head_tag_o,
    output logic                empty_o
);

    // Circular storage of free tags
    phys_pkg::phys_tag_t fl_q [`FL_DEPTH];

    phys_pkg::fl_ptr_t head_q;
    phys_pkg::fl_ptr_t tail_q;
    phys_pkg::fl_cnt_t cnt_q;

    //----------------------------------------------------------------------
    // Status
    //----------------------------------------------------------------------

    // Both reflect the state before the edge
    assign head_tag_o = fl_q[head_q];
    assign empty_o    = (cnt_q == '0);

    //----------------------------------------------------------------------
    // Storage
    //----------------------------------------------------------------------

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            // Tags 32..63 in rising order, 32 at the head
            for (int i = 0; i < `FL_DEPTH; i++) begin
                fl_q[i] <= phys_pkg::phys_tag_t'(`ARCH_REG_NUM + i);
            end
        end else if (push_i) begin
            // Retired tag appended behind the reset tags
            fl_q[tail_q] <= push_tag_i;
        end
    end

    //----------------------------------------------------------------------
    // Pointers and occupancy
    //----------------------------------------------------------------------

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            // Full after reset, so head and tail coincide
            head_q <= '0;
            tail_q <= '0;
            cnt_q  <= phys_pkg::fl_cnt_t'(`FL_DEPTH);
        end else begin
            if (pop_i) begin
                head_q <= head_q + 1'b1;
            end
            if (push_i) begin
                tail_q <= tail_q + 1'b1;
            end
            // Push and pop together leave the count alone
            case ({push_i, pop_i})
                2'b10:   cnt_q <= cnt_q + 1'b1;
                2'b01:   cnt_q <= cnt_q - 1'b1;
                default: cnt_q <= cnt_q;
            endcase
        end
    end

endmodule

// File: logic/map_table.sv
//--------------------------------------------------------------------------
// Rename map table
//--------------------------------------------------------------------------

`timescale 1ns/1ps

`include "rename_config.svh"

module map_table (
    input  logic                clk_i,
    input  logic                rst_i,
    // Source 1, source 2, destination lookup
    input  arch_pkg::arch_reg_t rd1_idx_i,
    input  arch_pkg::arch_reg_t rd2_idx_i,
    input  arch_pkg::arch_reg_t rd3_idx_i,
    output phys_pkg::phys_tag_t rd1_tag_o,
    output phys_pkg::phys_tag_t rd2_tag_o,
    output phys_pkg::phys_tag_t rd3_tag_o,
    // New mapping from the rename controller
    input  logic                wr_en_i,
    input  arch_pkg::arch_reg_t wr_idx_i,
    input  phys_pkg::phys_tag_t wr_tag_i
);

    // One physical tag per architectural register
    phys_pkg::phys_tag_t map_q [`ARCH_REG_NUM];

    //----------------------------------------------------------------------
    // Read ports
    //----------------------------------------------------------------------

    // Combinational, show the mapping before this cycle's write
    assign rd1_tag_o = map_q[rd1_idx_i];
    assign rd2_tag_o = map_q[rd2_idx_i];
    // Old mapping of the destination, freed later at retire
    assign rd3_tag_o = map_q[rd3_idx_i];

    //----------------------------------------------------------------------
    // Write port
    //----------------------------------------------------------------------

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            // Identity mapping, reg r on tag r
            for (int i = 0; i < `ARCH_REG_NUM; i++) begin
                map_q[i] <= phys_pkg::phys_tag_t'(i);
            end
        end else if (wr_en_i) begin
            // Controller never writes reg 0
            map_q[wr_idx_i] <= wr_tag_i;
        end
    end

endmodule

// File: logic/phys_pkg.sv
//--------------------------------------------------------------------------
// Physical tag and free-list types
//--------------------------------------------------------------------------

`include "rename_config.svh"

package phys_pkg;

    // Physical register tag, tag 0 stays bound to arch reg 0
    typedef logic [`PHY_TAG_WIDTH-1:0] phys_tag_t;

    // Head and tail pointers of the free list
    typedef logic [`FL_PTR_WIDTH-1:0] fl_ptr_t;

    // Occupancy needs one extra bit to hold a full list
    typedef logic [`FL_PTR_WIDTH:0] fl_cnt_t;

endpackage

// File: logic/arch_pkg.sv
//--------------------------------------------------------------------------
// Architectural register types
//--------------------------------------------------------------------------

`include "rename_config.svh"

package arch_pkg;

    // Index into the architectural register file
    typedef logic [`ARCH_IDX_WIDTH-1:0] arch_reg_t;

endpackage

// File: logic/rename_config.svh
//--------------------------------------------------------------------------
// Rename stage sizing
//--------------------------------------------------------------------------

`ifndef RENAME_CONFIG_SVH
`define RENAME_CONFIG_SVH

// Architectural register file
`define ARCH_REG_NUM        32
`define ARCH_IDX_WIDTH      5

// Physical register file
`define PHY_REG_NUM         64
`define PHY_TAG_WIDTH       6

//--------------------------------------------------------------------------
// Free list
//--------------------------------------------------------------------------

// Tags above the architectural range start out free
`define FL_DEPTH            (`PHY_REG_NUM - `ARCH_REG_NUM)
// Pointer wraps naturally at FL_DEPTH
`define FL_PTR_WIDTH        5

`endif
